// File: filelist.f
+incdir+verilog
verilog/hci_pkg.sv
verilog/hci_core_if.sv
verilog/hci_mux_dynamic.sv
verilog/hci_mem_bank.sv
verilog/hci_mux_subsys.sv
dv/hci_checker.sv
dv/tb_hci_mux_subsys.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_hci_mux_subsys
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := Something failed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A non-zero exit (e.g. a failed assertion) also counts as failure
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation did not pass"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_hci_mux_subsys.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI mux subsystem testbench
// Random channel traffic with bank stalls and clear pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "hci_macros.svh"

module tb_hci_mux_subsys
  import hci_pkg::*;
();

  localparam int unsigned n_phases     = 4;
  localparam int unsigned txn_per_chan = 60;
  localparam int unsigned cyc_per_txn  = 12;
  localparam int unsigned max_cycles   = n_phases * txn_per_chan * cyc_per_txn + 200;
  localparam logic [31:0] seed         = 32'h7fa3_1096;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   clear;
  logic [`HCI_NB_OUT-1:0] bank_stall;
  logic [`HCI_NB_IN-1:0]  in_req;
  hci_addr_t              in_add    [`HCI_NB_IN];
  logic [`HCI_NB_IN-1:0]  in_wen;
  hci_be_t                in_be     [`HCI_NB_IN];
  hci_data_t              in_data   [`HCI_NB_IN];
  logic [`HCI_NB_IN-1:0]  in_gnt;
  hci_data_t              in_r_data [`HCI_NB_IN];
  logic [`HCI_NB_IN-1:0]  in_r_valid;
  int unsigned            errors;
  int unsigned            xfers;

  // One generator per channel, the last one for stalls
  logic [31:0]            rng  [`HCI_NB_IN + 1];
  int unsigned            left [`HCI_NB_IN];
  int unsigned            idle [`HCI_NB_IN];
  logic [`HCI_NB_IN-1:0]  gnt_seen;

  hci_mux_subsys u_hci_mux_subsys (.*);

  hci_checker u_hci_checker (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic traffic_pending();
    logic busy;
    busy = (in_req != '0);
    for (int j = 0; j < `HCI_NB_IN; j++) begin
      busy |= (left[j] != 0) || (idle[j] != 0);
    end
    return busy;
  endfunction

  // Held until granted, then a short random gap
  task automatic step_channel(input int j);
    logic [31:0] r;
    if (in_req[j] && !gnt_seen[j]) begin
      return;
    end
    in_req[j] = 1'b0;
    if (idle[j] != 0) begin
      idle[j]--;
      return;
    end
    if (left[j] == 0) begin
      return;
    end
    rng[j]     = xorshift(rng[j]);
    r          = rng[j];
    in_req[j]  = 1'b1;
    in_wen[j]  = r[0];
    in_add[j]  = {4'h0, r[4:1]};
    in_be[j]   = r[8:5];
    idle[j]    = 32'(r[10:9]);
    rng[j]     = xorshift(rng[j]);
    in_data[j] = rng[j];
    left[j]--;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(max_cycles * 8);
    $display("Timeout: the traffic did not finish within %0d cycles", max_cycles);
    $display("Something failed");
    $finish;
  end

  initial begin : stimulus
    rst_ni     = 1'b0;
    clear      = 1'b0;
    bank_stall = '0;
    in_req     = '0;
    in_wen     = '0;
    for (int j = 0; j <= `HCI_NB_IN; j++) begin
      rng[j] = xorshift(seed ^ 32'(j));
    end
    for (int j = 0; j < `HCI_NB_IN; j++) begin
      in_add[j]  = '0;
      in_be[j]   = '0;
      in_data[j] = '0;
      left[j]    = 0;
      idle[j]    = 0;
    end
    repeat (16) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    for (int p = 0; p < n_phases; p++) begin
      // All channels start together so the pointer reset value is exercised
      for (int j = 0; j < `HCI_NB_IN; j++) begin
        left[j] = txn_per_chan;
      end
      do begin
        @(negedge clk_i);
        gnt_seen = in_gnt;
        @(posedge clk_i);
        #1;
        rng[`HCI_NB_IN] = xorshift(rng[`HCI_NB_IN]);
        for (int b = 0; b < `HCI_NB_OUT; b++) begin
          bank_stall[b] = (rng[`HCI_NB_IN][2*b +: 2] == 2'b00);
        end
        for (int j = 0; j < `HCI_NB_IN; j++) begin
          step_channel(j);
        end
      end while (traffic_pending());
      // Last response has drained before the clear pulse
      repeat (2) @(posedge clk_i);
      #1 clear = 1'b1;
      @(posedge clk_i);
      #1 clear = 1'b0;
    end
    repeat (4) @(posedge clk_i);
    $display("Run complete: %0d transfers, %0d errors", xfers, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: dv/hci_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI subsystem checker with bank memory and round-robin model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "hci_macros.svh"

module hci_checker
  import hci_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear,
  input  logic [`HCI_NB_OUT-1:0] bank_stall,
  input  logic [`HCI_NB_IN-1:0]  in_req,
  input  hci_addr_t              in_add    [`HCI_NB_IN],
  input  logic [`HCI_NB_IN-1:0]  in_wen,
  input  hci_be_t                in_be     [`HCI_NB_IN],
  input  hci_data_t              in_data   [`HCI_NB_IN],
  input  logic [`HCI_NB_IN-1:0]  in_gnt,
  input  hci_data_t              in_r_data [`HCI_NB_IN],
  input  logic [`HCI_NB_IN-1:0]  in_r_valid,
  output int unsigned            errors,
  output int unsigned            xfers
);

  hci_data_t             mem      [`HCI_NB_OUT][`HCI_BANK_WORDS];
  hci_data_t             exp_data [`HCI_NB_IN];
  hci_sel_t              ptr      [`HCI_NB_OUT];
  logic [`HCI_NB_IN-1:0] exp_rv;
  logic [`HCI_NB_IN-1:0] exp_rd;

  function automatic hci_data_t merge_bytes(hci_data_t old_word, hci_data_t new_word,
                                            hci_be_t be);
    hci_data_t res;
    res = old_word;
    for (int b = 0; b < `HCI_DW / 8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Sampled mid-cycle away from the clock edge
  always @(negedge clk_i) begin : compare
    logic [1:0]            exp_g;
    logic [1:0]            got;
    logic [`HCI_NB_IN-1:0] exp_gnt;
    hci_sel_t              win;
    int                    c1;
    if (!rst_ni) begin
      xfers  = 0;
      exp_rv = '0;
      exp_rd = '0;
      for (int p = 0; p < `HCI_NB_OUT; p++) begin
        ptr[p] = '0;
        for (int w = 0; w < `HCI_BANK_WORDS; w++) begin
          mem[p][w] = '0;
        end
      end
      if (in_gnt !== '0 || in_r_valid !== '0) begin
        errors++;
        $display("error during reset in_gnt 0x%h in_r_valid 0x%h", in_gnt, in_r_valid);
      end
    end else begin
      // Responses to last cycle's transfers
      for (int j = 0; j < `HCI_NB_IN; j++) begin
        if (in_r_valid[j] !== exp_rv[j]) begin
          errors++;
          $display("error in_r_valid ch%0d exp 0x%h got 0x%h", j, exp_rv[j], in_r_valid[j]);
        end else if (exp_rv[j] && exp_rd[j] && in_r_data[j] !== exp_data[j]) begin
          errors++;
          $display("error in_r_data ch%0d exp 0x%08h got 0x%08h", j, exp_data[j],
                   in_r_data[j]);
        end
      end
      // Stall and pointer rule decide the grant
      for (int p = 0; p < `HCI_NB_OUT; p++) begin
        c1    = p + `HCI_NB_OUT;
        exp_g = '0;
        win   = (in_req[p] && in_req[c1]) ? ptr[p] : hci_sel_t'(in_req[c1]);
        if (!bank_stall[p] && (in_req[p] || in_req[c1])) begin
          exp_g[win] = 1'b1;
        end
        exp_gnt[p]  = exp_g[0];
        exp_gnt[c1] = exp_g[1];
        got = {in_gnt[c1], in_gnt[p]};
        if (got !== exp_g) begin
          errors++;
          $display("error in_gnt port%0d exp 0x%h got 0x%h", p, exp_g, got);
        end
        if (clear) begin
          ptr[p] = '0;
        end else if (exp_g != '0 && in_req[p] && in_req[c1]) begin
          ptr[p] = ~win;
        end
      end
      // Channel j lives on bank j mod 2
      for (int j = 0; j < `HCI_NB_IN; j++) begin
        if (in_req[j] && exp_gnt[j]) begin
          xfers++;
          if (in_wen[j]) begin
            exp_data[j] = mem[j % `HCI_NB_OUT][in_add[j]];
          end else begin
            mem[j % `HCI_NB_OUT][in_add[j]] =
              merge_bytes(mem[j % `HCI_NB_OUT][in_add[j]], in_data[j], in_be[j]);
          end
        end
      end
      exp_rv = (in_req & exp_gnt) & {`HCI_NB_IN{!clear}};
      exp_rd = in_wen;
    end
  end

endmodule

// File: verilog/hci_mux_subsys.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI mux subsystem, four channels onto two memory banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "hci_macros.svh"

module hci_mux_subsys
  import hci_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear,
  input  logic [`HCI_NB_OUT-1:0] bank_stall,

  // Channel request side
  input  logic [`HCI_NB_IN-1:0]  in_req,
  input  hci_addr_t              in_add     [`HCI_NB_IN],
  input  logic [`HCI_NB_IN-1:0]  in_wen,
  input  hci_be_t                in_be      [`HCI_NB_IN],
  input  hci_data_t              in_data    [`HCI_NB_IN],

  // Channel grant and response side
  output logic [`HCI_NB_IN-1:0]  in_gnt,
  output hci_data_t              in_r_data  [`HCI_NB_IN],
  output logic [`HCI_NB_IN-1:0]  in_r_valid
);

  hci_core_if chan    [`HCI_NB_IN] ();
  hci_core_if bank_if [`HCI_NB_OUT] ();

  // Plain ports onto the channel interfaces
  for (genvar j = 0; j < `HCI_NB_IN; j++) begin : gen_chan
    assign chan[j].req  = in_req[j];
    assign chan[j].add  = in_add[j];
    assign chan[j].wen  = in_wen[j];
    assign chan[j].be   = in_be[j];
    assign chan[j].data = in_data[j];

    assign in_gnt[j]     = chan[j].gnt;
    assign in_r_data[j]  = chan[j].r_data;
    assign in_r_valid[j] = chan[j].r_valid;
  end

  hci_mux_dynamic u_hci_mux_dynamic (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clear  (clear),
    .in     (chan),
    .out    (bank_if)
  );

  // One bank behind every mux port
  for (genvar b = 0; b < `HCI_NB_OUT; b++) begin : gen_bank
    hci_mem_bank u_hci_mem_bank (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .stall  (bank_stall[b]),
      .port   (bank_if[b])
    );
  end

endmodule

// File: verilog/hci_mem_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI single-port memory bank with byte-enabled writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "hci_macros.svh"

module hci_mem_bank
  import hci_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       stall,

  hci_core_if.target port
);

  hci_data_t mem [`HCI_BANK_WORDS];
  hci_data_t wmask;
  hci_data_t r_data_q;
  logic      r_valid_q;
  logic      xfer;

  // Stall models contention from outside the slice
  assign port.gnt = port.req & ~stall;
  assign xfer     = port.req & port.gnt;

  // Expand byte enables to a bit mask
  always_comb begin
    for (int b = 0; b < `HCI_DW / 8; b++) begin
      wmask[8*b +: 8] = {8{port.be[b]}};
    end
  end

  // Whole array cleared at reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < `HCI_BANK_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (xfer && !port.wen) begin
      mem[port.add] <= (mem[port.add] & ~wmask) | (port.data & wmask);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_data_q  <= '0;
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= xfer;
      if (xfer && port.wen) begin
        r_data_q <= mem[port.add];
      end
    end
  end

  assign port.r_data  = r_data_q;
  assign port.r_valid = r_valid_q;

  a_resp_next_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    xfer |=> port.r_valid
  );

  // Full-word write then read of the same word returns the written data
  a_read_after_write: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (xfer && !port.wen && (port.be == '1))
      ##1 (xfer && port.wen && (port.add == $past(port.add)))
      |=> (port.r_data == $past(port.data, 2))
  );

endmodule

// File: verilog/hci_mux_dynamic.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI dynamic mux, round-robin from channel groups to ports
// Responses steered back by the registered winner
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

`include "hci_macros.svh"

module hci_mux_dynamic
  import hci_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clear,

  hci_core_if.target      in  [`HCI_NB_IN],
  hci_core_if.initiator   out [`HCI_NB_OUT]
);

  localparam int unsigned nb_in  = `HCI_NB_IN;
  localparam int unsigned nb_out = `HCI_NB_OUT;
  localparam int unsigned nb_grp = nb_in / nb_out;

  // Per-port views back towards the channels
  logic [nb_grp-1:0] grp_gnt    [nb_out];
  logic [nb_grp-1:0] grp_rvalid [nb_out];
  hci_data_t         out_r_data [nb_out];

  for (genvar i = 0; i < nb_out; i++) begin : gen_port
    logic [nb_grp-1:0] req_grp;
    hci_addr_t         add_grp  [nb_grp];
    logic [nb_grp-1:0] wen_grp;
    hci_be_t           be_grp   [nb_grp];
    hci_data_t         data_grp [nb_grp];

    hci_sel_t          ptr_q;
    hci_sel_t          winner_d;
    hci_sel_t          winner_q;
    logic [nb_grp-1:0] win_oh;
    logic              req_any;
    logic              out_req_q;
    logic              xfer;
    logic              other_req;

    // Channel g*nb_out+i belongs to port i
    for (genvar g = 0; g < nb_grp; g++) begin : gen_grp
      assign req_grp[g]  = in[g*nb_out+i].req;
      assign add_grp[g]  = in[g*nb_out+i].add;
      assign wen_grp[g]  = in[g*nb_out+i].wen;
      assign be_grp[g]   = in[g*nb_out+i].be;
      assign data_grp[g] = in[g*nb_out+i].data;
    end

    assign req_any = |req_grp;

    // Pointed-to channel has top priority, then upwards with wrap
    always_comb begin : winner_sel
      hci_sel_t cand;
      winner_d = ptr_q;
      for (int k = nb_grp - 1; k >= 0; k--) begin
        cand = ptr_q + hci_sel_t'(k);
        if (req_grp[cand]) begin
          winner_d = cand;
        end
      end
    end

    assign win_oh = nb_grp'(1) << winner_d;

    // Request path to the bank
    assign out[i].req  = req_any;
    assign out[i].add  = add_grp[winner_d];
    assign out[i].wen  = wen_grp[winner_d];
    assign out[i].be   = be_grp[winner_d];
    assign out[i].data = data_grp[winner_d];

    assign grp_gnt[i] = out[i].gnt ? win_oh : '0;

    assign xfer      = req_any & out[i].gnt;
    assign other_req = |(req_grp & ~win_oh);

    // Hand priority to the next channel only when someone else waits
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        ptr_q <= '0;
      end else if (clear) begin
        ptr_q <= '0;
      end else if (xfer && other_req) begin
        ptr_q <= winner_d + 1'b1;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        winner_q  <= '0;
        out_req_q <= 1'b0;
      end else if (clear) begin
        winner_q  <= '0;
        out_req_q <= 1'b0;
      end else begin
        winner_q  <= winner_d;
        out_req_q <= req_any;
      end
    end

    assign grp_rvalid[i] = (out[i].r_valid && out_req_q) ? (nb_grp'(1) << winner_q) : '0;
    assign out_r_data[i] = out[i].r_data;

    // The bank grant must land on exactly one requesting channel
    a_gnt_one_requester: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      $onehot0(grp_gnt[i]) && ((grp_gnt[i] & ~req_grp) == '0)
    );
  end

  for (genvar j = 0; j < nb_in; j++) begin : gen_chan
    localparam int unsigned port_idx = j % nb_out;
    localparam int unsigned grp_idx  = j / nb_out;

    assign in[j].gnt     = grp_gnt[port_idx][grp_idx];
    assign in[j].r_valid = grp_rvalid[port_idx][grp_idx];
    assign in[j].r_data  = grp_rvalid[port_idx][grp_idx] ? out_r_data[port_idx] : '0;

    // No response without a transfer on this channel the cycle before
    a_rvalid_after_xfer: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      in[j].r_valid |-> $past(in[j].req && in[j].gnt)
    );
  end

endmodule

// File: verilog/hci_core_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI memory channel, req/gnt request with r_valid response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

interface hci_core_if
  import hci_pkg::*;
();

  // Request phase
  logic      req;
  logic      gnt;
  hci_addr_t add;
  logic      wen;   // high for read
  hci_be_t   be;
  hci_data_t data;

  // Response phase, one cycle after the transfer
  hci_data_t r_data;
  logic      r_valid;

  modport initiator (
    output req, add, wen, be, data,
    input  gnt, r_data, r_valid
  );

  modport target (
    input  req, add, wen, be, data,
    output gnt, r_data, r_valid
  );

endinterface

// File: verilog/hci_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI package with shared word, address and select types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "hci_macros.svh"

package hci_pkg;

  // One bus word
  typedef logic [`HCI_DW-1:0] hci_data_t;

  // Word address inside one bank
  typedef logic [`HCI_AW-1:0] hci_addr_t;

  // One enable per byte lane
  typedef logic [`HCI_DW/8-1:0] hci_be_t;

  // Channel index within the group served by one port
  typedef logic [$clog2(`HCI_NB_IN/`HCI_NB_OUT)-1:0] hci_sel_t;

endpackage

// File: verilog/hci_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// HCI interconnect slice sizing
// Data, address, channel and bank dimensions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef HCI_MACROS_SVH
`define HCI_MACROS_SVH

// Word and bank geometry
`define HCI_DW         32
`define HCI_AW         8
`define HCI_BANK_WORDS 256

// Initiator channels in, memory ports out.
// The ratio must stay a power of two
`define HCI_NB_IN      4
`define HCI_NB_OUT     2

`endif
